/* verilog.f */
dcachePkg.sv
cacheCtrl.sv
tagStore.sv
dataStore.sv
refillBuffer.sv
dcacheTop.sv
tbMemModel.sv
tbDcache.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tbDcache
FILELIST := verilog.f

SOURCES  := $(shell cat $(FILELIST))
BINARY   := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf obj_dir

/* tbDcache.sv */
`default_nettype none

module tbDcache
  import dcachePkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam wordT PatternKey = 64'h5a3c_96e1_0f7b_d248;
  localparam int RandomOps = 400;
  localparam int ReadyTimeout = 100;
  localparam int RspTimeout = 200;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    wordT                 data;
    maskT                 mask;
    logic                 expHit;
  } stimT;

  // directed sequence on set 5
  stimT stimTable [9] = '{
    '{32'h0000_00a0, 1'b0, 64'h0, 8'h00, 1'b0},
    '{32'h0000_00b8, 1'b0, 64'h0, 8'h00, 1'b1},
    '{32'h0000_00ab, 1'b1, 64'h1122_3344_5566_7788, 8'h06, 1'b1},
    '{32'h0000_00a8, 1'b0, 64'h0, 8'h00, 1'b1},
    '{32'h0000_08a0, 1'b0, 64'h0, 8'h00, 1'b0},
    '{32'h0000_10a0, 1'b0, 64'h0, 8'h00, 1'b0},
    '{32'h0000_00a8, 1'b0, 64'h0, 8'h00, 1'b0},
    '{32'h0000_00ae, 1'b1, 64'hcafe_f00d_1234_5678, 8'hff, 1'b1},
    '{32'h0000_00a8, 1'b0, 64'h0, 8'h00, 1'b1}
  };

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 reqValid;
  cacheAddrT            reqAddr;
  logic                 reqWrite;
  wordT                 wrData;
  maskT                 wrMask;
  logic                 reqReady;
  logic                 rspValid;
  wordT                 rdData;
  logic                 wrValid;
  logic [AddrWidth-1:0] wrAddr;
  lineT                 wrLine;
  logic                 wrReady;
  logic                 rdValid;
  logic [AddrWidth-1:0] rdAddr;
  logic                 memReady;
  wordT                 memData;
  logic                 dataValid;
  logic                 rdLast;
  int                   wbCount;
  logic [AddrWidth-1:0] wbAddr;
  lineT                 wbLine;

  // reference model: flat byte memory and cache bookkeeping
  logic [7:0]                      refMem [logic [AddrWidth-1:0]];
  logic [TagWidth-1:0]             mTag [2][2**IndexWidth];
  logic [1:0][2**IndexWidth-1:0]   mValid;
  logic [1:0][2**IndexWidth-1:0]   mDirty;
  logic                            mVictim;
  int                              expWbCount;

  always #4 clk = ~clk;

  dcacheTop #(
    .NumSets (64)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid),
    .reqAddr_i   (reqAddr),
    .reqWrite_i  (reqWrite),
    .wrData_i    (wrData),
    .wrMask_i    (wrMask),
    .reqReady_o  (reqReady),
    .rspValid_o  (rspValid),
    .rdData_o    (rdData),
    .wrValid_o   (wrValid),
    .wrAddr_o    (wrAddr),
    .wrLine_o    (wrLine),
    .wrReady_i   (wrReady),
    .rdValid_o   (rdValid),
    .rdAddr_o    (rdAddr),
    .memReady_i  (memReady),
    .rdData_i    (memData),
    .dataValid_i (dataValid),
    .rdLast_i    (rdLast)
  );

  tbMemModel #(
    .PatternKey (PatternKey)
  ) memModel (
    .clk         (clk),
    .wrValid_i   (wrValid),
    .wrAddr_i    (wrAddr),
    .wrLine_i    (wrLine),
    .wrReady_o   (wrReady),
    .rdValid_i   (rdValid),
    .rdAddr_i    (rdAddr),
    .memReady_o  (memReady),
    .rdData_o    (memData),
    .dataValid_o (dataValid),
    .rdLast_o    (rdLast),
    .wbCount_o   (wbCount),
    .wbAddr_o    (wbAddr),
    .wbLine_o    (wbLine)
  );

  task automatic stopOnError(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(string name, wordT got, wordT exp);
    if (got !== exp) begin
      stopOnError($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkLine(string name, lineT got, lineT exp);
    if (got !== exp) begin
      stopOnError($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkAddr(string name, logic [AddrWidth-1:0] got, logic [AddrWidth-1:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkCount(string name, int got, int exp);
    if (got != exp) begin
      stopOnError($sformatf("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // untouched bytes read back as the initial pattern
  function automatic logic [7:0] refByte(logic [AddrWidth-1:0] a);
    wordT pat;
    pat = PatternKey ^ wordT'({a[AddrWidth-1:3], 3'b000});
    if (refMem.exists(a)) begin
      return refMem[a];
    end
    return pat[a[2:0]*8 +: 8];
  endfunction

  function automatic wordT refWord(logic [AddrWidth-1:0] a);
    wordT w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = refByte({a[AddrWidth-1:3], 3'(b)});
    end
    return w;
  endfunction

  task automatic predict(logic [AddrWidth-1:0] addr, logic write, wordT data, maskT mask,
                         output logic hit, output logic wb,
                         output logic [AddrWidth-1:0] wbA, output lineT wbL);
    cacheAddrT a;
    int        way;
    int        v;
    int        lane;
    a.raw = addr;
    hit = 1'b0;
    wb = 1'b0;
    way = 0;
    wbA = '0;
    wbL = '0;
    for (int w = 0; w < 2; w++) begin
      if (mValid[w][a.fields.index] && mTag[w][a.fields.index] == a.fields.tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      v = int'(mVictim);
      if (mValid[v][a.fields.index] && mDirty[v][a.fields.index]) begin
        wb = 1'b1;
        wbA = {mTag[v][a.fields.index], a.fields.index, OffsetWidth'(0)};
        for (int k = 0; k < LineWords; k++) begin
          wbL[k*XLen +: XLen] = refWord(wbA + 8 * k);
        end
      end
      mValid[v][a.fields.index] = 1'b1;
      mDirty[v][a.fields.index] = 1'b0;
      mTag[v][a.fields.index] = a.fields.tag;
      mVictim = !mVictim;
      way = v;
    end
    if (write) begin
      mDirty[way][a.fields.index] = 1'b1;
      // data byte b goes to the lane at byte offset plus b and is lost past lane 7
      for (int b = 0; b < 8; b++) begin
        lane = int'(addr[2:0]) + b;
        if (mask[b] && lane < 8) begin
          refMem[{addr[AddrWidth-1:3], 3'(lane)}] = data[b*8 +: 8];
        end
      end
    end
  endtask

  task automatic runRequest(logic [AddrWidth-1:0] addr, logic write, wordT data, maskT mask,
                            output int latency, output wordT got);
    int waitCnt;
    reqValid <= 1'b1;
    reqAddr.raw <= addr;
    reqWrite <= write;
    wrData <= data;
    wrMask <= mask;
    waitCnt = 0;
    @(negedge clk);
    while (!reqReady) begin
      waitCnt++;
      if (waitCnt > ReadyTimeout) begin
        stopOnError("timeout: reqReady_o never went high");
      end
      @(negedge clk);
    end
    // accepted on this edge
    @(posedge clk);
    reqValid <= 1'b0;
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
      if (latency > RspTimeout) begin
        stopOnError("timeout: no rspValid_o for an accepted request");
      end
    end while (!rspValid);
    got = rdData;
  endtask

  task automatic applyOp(logic [AddrWidth-1:0] addr, logic write, wordT data, maskT mask,
                         output logic hitExp);
    logic                 wbExp;
    logic [AddrWidth-1:0] wbA;
    lineT                 wbL;
    wordT                 expWord;
    wordT                 got;
    int                   lat;
    expWord = refWord(addr);
    predict(addr, write, data, mask, hitExp, wbExp, wbA, wbL);
    if (wbExp) begin
      expWbCount++;
    end
    @(posedge clk);
    runRequest(addr, write, data, mask, lat, got);
    if (hitExp) begin
      checkCount("rspValid_o latency", lat, 1);
    end else if (lat < 4) begin
      stopOnError("a miss completed without a memory refill");
    end
    if (!write) begin
      checkWord("rdData_o", got, expWord);
    end
    checkCount("write-back count", wbCount, expWbCount);
    if (wbExp) begin
      checkAddr("wrAddr_o", wbAddr, wbA);
      checkLine("wrLine_o", wbLine, wbL);
    end
  endtask

  // second load is accepted in the cycle the first one hits
  task automatic issueHitPair(logic [AddrWidth-1:0] addrA, logic [AddrWidth-1:0] addrB);
    logic                 hitA;
    logic                 hitB;
    logic                 wbExp;
    logic [AddrWidth-1:0] wbA;
    lineT                 wbL;
    wordT                 expA;
    wordT                 expB;
    int                   waitCnt;
    expA = refWord(addrA);
    expB = refWord(addrB);
    predict(addrA, 1'b0, '0, '0, hitA, wbExp, wbA, wbL);
    predict(addrB, 1'b0, '0, '0, hitB, wbExp, wbA, wbL);
    if (!hitA || !hitB) begin
      stopOnError("the back-to-back pair does not consist of two hits");
    end
    @(posedge clk);
    reqValid <= 1'b1;
    reqAddr.raw <= addrA;
    reqWrite <= 1'b0;
    waitCnt = 0;
    @(negedge clk);
    while (!reqReady) begin
      waitCnt++;
      if (waitCnt > ReadyTimeout) begin
        stopOnError("timeout: reqReady_o never went high");
      end
      @(negedge clk);
    end
    // first accepted here, second held right behind it
    @(posedge clk);
    reqAddr.raw <= addrB;
    @(negedge clk);
    checkFlag("rspValid_o", rspValid, 1'b1);
    checkWord("rdData_o", rdData, expA);
    checkFlag("reqReady_o", reqReady, 1'b1);
    @(posedge clk);
    reqValid <= 1'b0;
    @(negedge clk);
    checkFlag("rspValid_o", rspValid, 1'b1);
    checkWord("rdData_o", rdData, expB);
    checkCount("write-back count", wbCount, expWbCount);
  endtask

  initial begin
    logic                 hitModel;
    logic [AddrWidth-1:0] rAddr;
    logic                 rWrite;
    wordT                 rData;
    maskT                 rMask;
    void'($urandom(32'h046d_fa74));
    rst_n <= 1'b0;
    reqValid <= 1'b0;
    reqAddr <= '0;
    reqWrite <= 1'b0;
    wrData <= '0;
    wrMask <= '0;
    mValid = '0;
    mDirty = '0;
    mVictim = 1'b0;
    expWbCount = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checkFlag("reqReady_o", reqReady, 1'b1);
    checkFlag("rspValid_o", rspValid, 1'b0);
    checkFlag("wrValid_o", wrValid, 1'b0);
    checkFlag("rdValid_o", rdValid, 1'b0);

    for (int i = 0; i < 9; i++) begin
      applyOp(stimTable[i].addr, stimTable[i].write, stimTable[i].data, stimTable[i].mask,
              hitModel);
      checkFlag("predicted hit", hitModel, stimTable[i].expHit);
    end

    // both ways of set 5 hold lines now
    issueHitPair(32'h0000_00b0, 32'h0000_10b8);

    // four tags over sets 5..7 keep both ways busy
    for (int n = 0; n < RandomOps; n++) begin
      rAddr = {TagWidth'($urandom_range(3, 0)), IndexWidth'($urandom_range(7, 5)),
               OffsetWidth'($urandom)};
      rWrite = 1'($urandom_range(1, 0));
      rData = {$urandom, $urandom};
      rMask = 8'($urandom);
      applyOp(rAddr, rWrite, rData, rMask, hitModel);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tbMemModel.sv */
`default_nettype none

module tbMemModel
  import dcachePkg::*;
#(
  parameter wordT PatternKey = '0
) (
  input  logic                 clk,
  input  logic                 wrValid_i,
  input  logic [AddrWidth-1:0] wrAddr_i,
  input  lineT                 wrLine_i,
  output logic                 wrReady_o,
  input  logic                 rdValid_i,
  input  logic [AddrWidth-1:0] rdAddr_i,
  output logic                 memReady_o,
  output wordT                 rdData_o,
  output logic                 dataValid_o,
  output logic                 rdLast_o,
  output int                   wbCount_o,
  output logic [AddrWidth-1:0] wbAddr_o,
  output lineT                 wbLine_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // written-back lines override the initial pattern
  lineT wbMem [logic [AddrWidth-1:0]];

  function automatic wordT lineWord(logic [AddrWidth-1:0] lineAddr, int beat);
    lineT l;
    if (wbMem.exists(lineAddr)) begin
      l = wbMem[lineAddr];
      return l[beat*XLen +: XLen];
    end
    return PatternKey ^ wordT'(lineAddr + beat * 8);
  endfunction

  task automatic randomWait(int maxCycles);
    int n;
    n = $urandom_range(maxCycles, 0);
    repeat (n) @(posedge clk);
  endtask

  task automatic serveWriteBack();
    randomWait(3);
    @(posedge clk);
    wrReady_o <= 1'b1;
    @(negedge clk);
    wbMem[wrAddr_i] = wrLine_i;
    wbAddr_o <= wrAddr_i;
    wbLine_o <= wrLine_i;
    wbCount_o <= wbCount_o + 1;
    @(posedge clk);
    wrReady_o <= 1'b0;
  endtask

  task automatic serveRefill();
    logic [AddrWidth-1:0] lineAddr;
    lineAddr = rdAddr_i;
    randomWait(3);
    @(posedge clk);
    memReady_o <= 1'b1;
    @(posedge clk);
    memReady_o <= 1'b0;
    for (int b = 0; b < LineWords; b++) begin
      // gap cycles with no beat
      repeat ($urandom_range(2, 0)) begin
        @(posedge clk);
        dataValid_o <= 1'b0;
      end
      @(posedge clk);
      dataValid_o <= 1'b1;
      rdData_o <= lineWord(lineAddr, b);
      rdLast_o <= (b == LineWords - 1);
    end
    @(posedge clk);
    dataValid_o <= 1'b0;
    rdLast_o <= 1'b0;
  endtask

  initial begin
    wrReady_o <= 1'b0;
    memReady_o <= 1'b0;
    rdData_o <= '0;
    dataValid_o <= 1'b0;
    rdLast_o <= 1'b0;
    wbCount_o <= 0;
    wbAddr_o <= '0;
    wbLine_o <= '0;
    forever begin
      @(negedge clk);
      if (wrValid_i) begin
        serveWriteBack();
      end else if (rdValid_i) begin
        serveRefill();
      end
    end
  end

endmodule

`default_nettype wire

/* dcacheTop.sv */
`default_nettype none

module dcacheTop
  import dcachePkg::*;
#(
  parameter int NumSets = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // load/store pipeline side
  input  logic                 reqValid_i,
  input  cacheAddrT            reqAddr_i,
  input  logic                 reqWrite_i,
  input  wordT                 wrData_i,
  input  maskT                 wrMask_i,
  output logic                 reqReady_o,
  output logic                 rspValid_o,
  output wordT                 rdData_o,
  // write-back channel
  output logic                 wrValid_o,
  output logic [AddrWidth-1:0] wrAddr_o,
  output lineT                 wrLine_o,
  input  logic                 wrReady_i,
  // refill channel
  output logic                 rdValid_o,
  output logic [AddrWidth-1:0] rdAddr_o,
  input  logic                 memReady_i,
  input  wordT                 rdData_i,
  input  logic                 dataValid_i,
  input  logic                 rdLast_i
);

  cacheAddrT           lookup;
  logic                storeEn;
  wordT                storeData;
  maskT                storeMask;
  logic                refillEn;
  logic                clearBuf;
  logic                beatEn;
  logic                hit;
  logic                hitWay;
  logic                victimWay;
  logic                victimDirty;
  logic [TagWidth-1:0] victimTag;
  lineT                refillLine;

  cacheCtrl u_cacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqAddr_i     (reqAddr_i),
    .reqWrite_i    (reqWrite_i),
    .wrData_i      (wrData_i),
    .wrMask_i      (wrMask_i),
    .hit_i         (hit),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .wrReady_i     (wrReady_i),
    .memReady_i    (memReady_i),
    .dataValid_i   (dataValid_i),
    .rdLast_i      (rdLast_i),
    .reqReady_o    (reqReady_o),
    .rspValid_o    (rspValid_o),
    .lookup_o      (lookup),
    .storeEn_o     (storeEn),
    .storeData_o   (storeData),
    .storeMask_o   (storeMask),
    .refillEn_o    (refillEn),
    .clearBuf_o    (clearBuf),
    .beatEn_o      (beatEn),
    .wrValid_o     (wrValid_o),
    .wrAddr_o      (wrAddr_o),
    .rdValid_o     (rdValid_o),
    .rdAddr_o      (rdAddr_o)
  );

  tagStore #(
    .NumSets (NumSets)
  ) u_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookup_i      (lookup),
    .storeEn_i     (storeEn),
    .refillEn_i    (refillEn),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore #(
    .NumSets (NumSets)
  ) u_dataStore (
    .clk          (clk),
    .lookup_i     (lookup),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .storeEn_i    (storeEn),
    .storeData_i  (storeData),
    .storeMask_i  (storeMask),
    .refillEn_i   (refillEn),
    .refillLine_i (refillLine),
    .readWord_o   (rdData_o),
    .victimLine_o (wrLine_o)
  );

  refillBuffer u_refillBuffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .clearBuf_i   (clearBuf),
    .beatEn_i     (beatEn),
    .rdData_i     (rdData_i),
    .refillLine_o (refillLine)
  );

endmodule

`default_nettype wire

/* refillBuffer.sv */
`default_nettype none

module refillBuffer
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic clearBuf_i,
  input  logic beatEn_i,
  input  wordT rdData_i,
  output lineT refillLine_o
);

  logic [$clog2(LineWords)-1:0] beatCntQ;
  lineT                         lineQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCntQ <= '0;
    end else if (clearBuf_i) begin
      beatCntQ <= '0;
    end else if (beatEn_i) begin
      beatCntQ <= beatCntQ + 1'b1;
    end
  end

  // beat 0 fills the low word
  always_ff @(posedge clk) begin
    if (beatEn_i) begin
      lineQ[beatCntQ*XLen +: XLen] <= rdData_i;
    end
  end

  assign refillLine_o = lineQ;

endmodule

`default_nettype wire

/* dataStore.sv */
`default_nettype none

module dataStore
  import dcachePkg::*;
#(
  parameter int NumSets = 64
) (
  input  logic      clk,
  input  cacheAddrT lookup_i,
  input  logic      hitWay_i,
  input  logic      victimWay_i,
  input  logic      storeEn_i,
  input  wordT      storeData_i,
  input  maskT      storeMask_i,
  input  logic      refillEn_i,
  input  lineT      refillLine_i,
  output wordT      readWord_o,
  output lineT      victimLine_o
);

  lineT                  lineQ [2][NumSets];
  logic [IndexWidth-1:0] idx;
  logic [1:0]            wordSel;
  lineT                  hitLine;
  wordT                  oldWord;
  wordT                  bitMask;
  wordT                  mergedWord;

  assign idx = lookup_i.fields.index;
  // word within the line from offset bits 4:3
  assign wordSel = lookup_i.fields.offset[OffsetWidth-1:3];

  assign hitLine = lineQ[hitWay_i][idx];
  assign oldWord = hitLine[wordSel*XLen +: XLen];
  assign readWord_o = oldWord;
  assign victimLine_o = lineQ[victimWay_i][idx];

  // byte mask widened to one bit per data bit
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      bitMask[b*8 +: 8] = {8{storeMask_i[b]}};
    end
  end

  assign mergedWord = (oldWord & ~bitMask) | (storeData_i & bitMask);

  always_ff @(posedge clk) begin
    if (refillEn_i) begin
      lineQ[victimWay_i][idx] <= refillLine_i;
    end else if (storeEn_i) begin
      lineQ[hitWay_i][idx][wordSel*XLen +: XLen] <= mergedWord;
    end
  end

endmodule

`default_nettype wire

/* tagStore.sv */
`default_nettype none

module tagStore
  import dcachePkg::*;
#(
  parameter int NumSets = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  cacheAddrT           lookup_i,
  input  logic                storeEn_i,
  input  logic                refillEn_i,
  output logic                hit_o,
  output logic                hitWay_o,
  output logic                victimWay_o,
  output logic                victimDirty_o,
  output logic [TagWidth-1:0] victimTag_o
);

  logic [1:0][NumSets-1:0] validQ;
  logic [1:0][NumSets-1:0] dirtyQ;
  logic [TagWidth-1:0]     tagQ [2][NumSets];
  logic                    victimWayQ;
  logic [IndexWidth-1:0]   idx;
  logic [1:0]              wayHit;

  assign idx = lookup_i.fields.index;

  // both ways compared in parallel
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validQ[w][idx] && (tagQ[w][idx] == lookup_i.fields.tag);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];

  assign victimWay_o = victimWayQ;
  assign victimDirty_o = dirtyQ[victimWayQ][idx];
  assign victimTag_o = tagQ[victimWayQ][idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
      victimWayQ <= 1'b0;
    end else if (refillEn_i) begin
      // fresh line is clean; next miss goes to the other way
      validQ[victimWayQ][idx] <= 1'b1;
      dirtyQ[victimWayQ][idx] <= 1'b0;
      victimWayQ <= ~victimWayQ;
    end else if (storeEn_i) begin
      dirtyQ[wayHit[1]][idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (refillEn_i) begin
      tagQ[victimWayQ][idx] <= lookup_i.fields.tag;
    end
  end

endmodule

`default_nettype wire

/* cacheCtrl.sv */
`default_nettype none

module cacheCtrl
  import dcachePkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // pipeline request
  input  logic                 reqValid_i,
  input  cacheAddrT            reqAddr_i,
  input  logic                 reqWrite_i,
  input  wordT                 wrData_i,
  input  maskT                 wrMask_i,
  // tag store status
  input  logic                 hit_i,
  input  logic                 victimDirty_i,
  input  logic [TagWidth-1:0]  victimTag_i,
  // memory handshakes
  input  logic                 wrReady_i,
  input  logic                 memReady_i,
  input  logic                 dataValid_i,
  input  logic                 rdLast_i,
  output logic                 reqReady_o,
  output logic                 rspValid_o,
  output cacheAddrT            lookup_o,
  output logic                 storeEn_o,
  output wordT                 storeData_o,
  output maskT                 storeMask_o,
  output logic                 refillEn_o,
  output logic                 clearBuf_o,
  output logic                 beatEn_o,
  output logic                 wrValid_o,
  output logic [AddrWidth-1:0] wrAddr_o,
  output logic                 rdValid_o,
  output logic [AddrWidth-1:0] rdAddr_o
);

  localparam logic [2:0] Idle      = 3'd0;
  localparam logic [2:0] Compare   = 3'd1;
  localparam logic [2:0] WriteBack = 3'd2;
  localparam logic [2:0] Fetch     = 3'd3;
  localparam logic [2:0] Refill    = 3'd4;
  localparam logic [2:0] Replace   = 3'd5;

  logic [2:0] stateQ;
  logic [2:0] stateD;
  cacheAddrT  reqAddrQ;
  logic       reqWriteQ;
  wordT       storeDataQ;
  maskT       storeMaskQ;
  logic       accept;
  logic       hitNow;

  assign hitNow = (stateQ == Compare) && hit_i;

  // new request can enter from idle or behind a hit
  assign reqReady_o = (stateQ == Idle) || hitNow;
  assign accept = reqValid_i && reqReady_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= Idle;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      Idle: begin
        if (reqValid_i) begin
          stateD = Compare;
        end
      end
      Compare: begin
        if (hit_i) begin
          stateD = reqValid_i ? Compare : Idle;
        end else if (victimDirty_i) begin
          stateD = WriteBack;
        end else begin
          stateD = Fetch;
        end
      end
      WriteBack: begin
        if (wrReady_i) begin
          stateD = Fetch;
        end
      end
      Fetch: begin
        if (memReady_i) begin
          stateD = Refill;
        end
      end
      Refill: begin
        if (dataValid_i && rdLast_i) begin
          stateD = Replace;
        end
      end
      // line and tag are written here, request retried in compare
      Replace: stateD = Compare;
      default: stateD = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqAddrQ <= '0;
      reqWriteQ <= 1'b0;
    end else if (accept) begin
      reqAddrQ <= reqAddr_i;
      reqWriteQ <= reqWrite_i;
    end
  end

  // store data and mask moved to their byte lane at acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      storeDataQ <= wrData_i << {reqAddr_i.raw[2:0], 3'b000};
      storeMaskQ <= wrMask_i << reqAddr_i.raw[2:0];
    end
  end

  assign lookup_o = reqAddrQ;
  assign storeData_o = storeDataQ;
  assign storeMask_o = storeMaskQ;

  assign rspValid_o = hitNow;
  assign storeEn_o = hitNow && reqWriteQ;
  assign refillEn_o = (stateQ == Replace);

  // beat counter restarts on every way into fetch
  assign clearBuf_o = ((stateQ == Compare) && !hit_i && !victimDirty_i) ||
                      ((stateQ == WriteBack) && wrReady_i);
  assign beatEn_o = (stateQ == Refill) && dataValid_i;

  assign wrValid_o = (stateQ == WriteBack);
  assign rdValid_o = (stateQ == Fetch);

  // line-aligned victim and refill addresses
  assign wrAddr_o = {victimTag_i, reqAddrQ.fields.index, {OffsetWidth{1'b0}}};
  assign rdAddr_o = {reqAddrQ.fields.tag, reqAddrQ.fields.index, {OffsetWidth{1'b0}}};

endmodule

`default_nettype wire

/* dcachePkg.sv */
`default_nettype none

package dcachePkg;

  // pipeline and bus widths
  localparam int XLen = 64;
  localparam int AddrWidth = 32;
  localparam int LineWords = 4;
  localparam int OffsetWidth = 5;

  // index bits match 64 sets, so the tag width follows from NumSets
  localparam int IndexWidth = 6;
  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  typedef logic [XLen-1:0] wordT;
  typedef logic [LineWords*XLen-1:0] lineT;
  typedef logic [7:0] maskT;

  // address split as seen by the tag and data arrays
  typedef struct packed {
    logic [TagWidth-1:0] tag;
    logic [IndexWidth-1:0] index;
    logic [OffsetWidth-1:0] offset;
  } cacheAddrFieldsT;

  // same request address, flat or split
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    cacheAddrFieldsT fields;
  } cacheAddrT;

endpackage

`default_nettype wire
